/* hdl/pte_pkg.sv */
/*
 * Page table entry types
 * A memory word is read either as a leaf, which maps a page, or as a
 * pointer to a second-level table. Both views share the valid and the
 * leaf bit in the low positions.
 */
`include "ptw_params.svh"

package pte_pkg;

	// Leaf view, maps a 4 KB page or a 4 MB superpage
	typedef struct packed {
		logic [`PTW_PPN_W-1:0]                 ppn;
		logic [`PTW_ADDR_W-`PTW_PPN_W-4:0]     rsvd;
		logic                                  glb;
		logic                                  leaf;
		logic                                  valid;
	} pte_leaf_t;

	// Pointer view, names the page of the next table
	typedef struct packed {
		logic [`PTW_PPN_W-1:0]                 tpn;
		logic [`PTW_ADDR_W-`PTW_PPN_W-3:0]     rsvd;
		logic                                  leaf;
		logic                                  valid;
	} pte_ptr_t;

	typedef union packed {
		pte_leaf_t leaf_view;
		pte_ptr_t  ptr_view;
	} pte_u;

endpackage

/* hdl/ptw_top.sv */
/*
 * Page table walker top level
 * Translation buffer lookup in front of a two-level walker, which reads
 * page table entries over a Wishbone classic read master.
 */
`timescale 1ns/1ns
`include "ptw_params.svh"

module ptw_top (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic [`PTW_ADDR_W-1:0] vadr_i,
	input  logic                   vadr_v_i,
	input  logic [`PTW_PPN_W-1:0]  ptbr_i,
	input  logic                   flush_i,
	input  logic                   clear_fault_i,
	output logic [`PTW_ADDR_W-1:0] padr_o,
	output logic                   padr_v_o,
	output logic                   page_fault_o,
	output logic                   wb_cyc_o,
	output logic                   wb_stb_o,
	output logic [`PTW_ADDR_W-1:0] wb_adr_o,
	input  logic [`PTW_ADDR_W-1:0] wb_dat_i,
	input  logic                   wb_ack_i,
	input  logic                   wb_err_i
);
	import tlb_pkg::*;

	logic                   miss;
	logic [`PTW_ADDR_W-1:0] miss_vadr;
	logic                   fill;
	tlb_entry_t             fill_entry;
	logic                   walk_done;
	logic                   rd_req;
	logic [`PTW_ADDR_W-1:0] rd_adr;
	logic                   rd_done;
	logic [`PTW_ADDR_W-1:0] rd_data;
	logic                   rd_err;

	tlb_lookup u_lookup (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.vadr_i       (vadr_i),
		.vadr_v_i     (vadr_v_i),
		.flush_i      (flush_i),
		.fill_i       (fill),
		.fill_entry_i (fill_entry),
		.walk_done_i  (walk_done),
		.padr_o       (padr_o),
		.padr_v_o     (padr_v_o),
		.miss_o       (miss),
		.miss_vadr_o  (miss_vadr)
	);

	ptw_walker u_walker (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.miss_i        (miss),
		.miss_vadr_i   (miss_vadr),
		.ptbr_i        (ptbr_i),
		.flush_i       (flush_i),
		.clear_fault_i (clear_fault_i),
		.rd_req_o      (rd_req),
		.rd_adr_o      (rd_adr),
		.rd_done_i     (rd_done),
		.rd_data_i     (rd_data),
		.rd_err_i      (rd_err),
		.fill_o        (fill),
		.fill_entry_o  (fill_entry),
		.walk_done_o   (walk_done),
		.page_fault_o  (page_fault_o)
	);

	wb_read_master u_master (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.rd_req_i  (rd_req),
		.rd_adr_i  (rd_adr),
		.rd_done_o (rd_done),
		.rd_data_o (rd_data),
		.rd_err_o  (rd_err),
		.wb_cyc_o  (wb_cyc_o),
		.wb_stb_o  (wb_stb_o),
		.wb_adr_o  (wb_adr_o),
		.wb_dat_i  (wb_dat_i),
		.wb_ack_i  (wb_ack_i),
		.wb_err_i  (wb_err_i)
	);

endmodule

/* hdl/ptw_walker.sv */
/*
 * Two-level page table walker
 * Reads the top-level entry, or takes it from the one-entry pointer
 * memory, then reads the second-level entry if needed. Builds the
 * buffer entry, or raises a sticky page fault.
 */
`timescale 1ns/1ns
`include "ptw_params.svh"

module ptw_walker (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   miss_i,
	input  logic [`PTW_ADDR_W-1:0] miss_vadr_i,
	input  logic [`PTW_PPN_W-1:0]  ptbr_i,
	input  logic                   flush_i,
	input  logic                   clear_fault_i,
	output logic                   rd_req_o,
	output logic [`PTW_ADDR_W-1:0] rd_adr_o,
	input  logic                   rd_done_i,
	input  logic [`PTW_ADDR_W-1:0] rd_data_i,
	input  logic                   rd_err_i,
	output logic                   fill_o,
	output tlb_pkg::tlb_entry_t    fill_entry_o,
	output logic                   walk_done_o,
	output logic                   page_fault_o
);
	import pte_pkg::*;
	import tlb_pkg::*;

	localparam int IDX_W = `PTW_LOG_SUPER - `PTW_LOG_PAGE;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_L1_WAIT,
		ST_L2_WAIT
	} state_t;

	state_t                 state_q;
	logic [`PTW_ADDR_W-1:0] vadr_q;
	logic                   ptr_v_q;
	logic [`PTW_ADDR_W-1:0] ptr_adr_q;
	logic [`PTW_PPN_W-1:0]  ptr_tpn_q;
	pte_u                   pte;
	logic [`PTW_ADDR_W-1:0] l1_adr;
	logic [`PTW_ADDR_W-1:0] l2_adr_cached;
	logic [`PTW_ADDR_W-1:0] l2_adr_fetched;
	logic                   ptr_hit;
	logic                   ptr_load;
	logic                   l1_fault;
	logic                   l2_fault;

	function automatic logic [`PTW_ADDR_W-1:0] page_base(input logic [`PTW_PPN_W-1:0] pn);
		return {pn, {`PTW_LOG_PAGE{1'b0}}};
	endfunction

	// Entries are four bytes wide
	function automatic logic [`PTW_ADDR_W-1:0] pte_offset(input logic [IDX_W-1:0] idx);
		return {{(`PTW_ADDR_W-IDX_W-2){1'b0}}, idx, 2'b00};
	endfunction

	function automatic tlb_entry_t make_entry(input logic sup, input pte_leaf_t lf,
	                                          input logic [`PTW_ADDR_W-1:0] va);
		tlb_entry_t e;
		e.valid = 1'b1;
		e.is_super = sup;
		e.glb = lf.glb;
		e.vtag = va[`PTW_ADDR_W-1:`PTW_LOG_PAGE];
		e.ppn = lf.ppn;
		return e;
	endfunction

	always_comb begin
		pte = rd_data_i;
		l1_adr = page_base(ptbr_i) + pte_offset(miss_vadr_i[`PTW_ADDR_W-1:`PTW_LOG_SUPER]);
		l2_adr_cached = page_base(ptr_tpn_q) +
		                pte_offset(miss_vadr_i[`PTW_LOG_SUPER-1:`PTW_LOG_PAGE]);
		l2_adr_fetched = page_base(pte.ptr_view.tpn) +
		                 pte_offset(vadr_q[`PTW_LOG_SUPER-1:`PTW_LOG_PAGE]);
		ptr_hit = ptr_v_q && (ptr_adr_q == l1_adr);
		// A superpage must start on a 4 MB boundary
		l1_fault = rd_err_i || !pte.leaf_view.valid ||
		           (pte.leaf_view.leaf && (pte.leaf_view.ppn[IDX_W-1:0] != '0));
		l2_fault = rd_err_i || !pte.leaf_view.valid || !pte.leaf_view.leaf;
		ptr_load = (state_q == ST_L1_WAIT) && rd_done_i && !l1_fault && !pte.ptr_view.leaf;
	end

	// ====================
	// Walk FSM
	// ====================
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= ST_IDLE;
			rd_req_o <= 1'b0;
			fill_o <= 1'b0;
			walk_done_o <= 1'b0;
			page_fault_o <= 1'b0;
			ptr_v_q <= 1'b0;
		end else begin
			rd_req_o <= 1'b0;
			fill_o <= 1'b0;
			walk_done_o <= 1'b0;
			if (clear_fault_i) begin
				page_fault_o <= 1'b0;
			end
			case (state_q)
				ST_IDLE: begin
					// The pointer memory lets the walk start at the second level
					if (miss_i) begin
						rd_req_o <= 1'b1;
						state_q <= ptr_hit ? ST_L2_WAIT : ST_L1_WAIT;
					end
				end
				ST_L1_WAIT: begin
					if (rd_done_i) begin
						if (l1_fault || pte.leaf_view.leaf) begin
							if (l1_fault) begin
								page_fault_o <= 1'b1;
							end
							fill_o <= !l1_fault;
							walk_done_o <= 1'b1;
							state_q <= ST_IDLE;
						end else begin
							ptr_v_q <= 1'b1;
							rd_req_o <= 1'b1;
							state_q <= ST_L2_WAIT;
						end
					end
				end
				ST_L2_WAIT: begin
					if (rd_done_i) begin
						if (l2_fault) begin
							page_fault_o <= 1'b1;
						end
						fill_o <= !l2_fault;
						walk_done_o <= 1'b1;
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
			if (flush_i) begin
				ptr_v_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == ST_IDLE && miss_i) begin
			vadr_q <= miss_vadr_i;
			rd_adr_o <= ptr_hit ? l2_adr_cached : l1_adr;
		end
		if (ptr_load) begin
			ptr_adr_q <= rd_adr_o;
			ptr_tpn_q <= pte.ptr_view.tpn;
			rd_adr_o <= l2_adr_fetched;
		end
		if (state_q == ST_L1_WAIT && rd_done_i) begin
			fill_entry_o <= make_entry(1'b1, pte.leaf_view, vadr_q);
		end
		if (state_q == ST_L2_WAIT && rd_done_i) begin
			fill_entry_o <= make_entry(1'b0, pte.leaf_view, vadr_q);
		end
	end

endmodule

/* hdl/tlb_lookup.sv */
/*
 * Translation buffer lookup
 * Fully associative buffer of eight entries with round-robin refill.
 * A hit returns the physical address one cycle after the request is
 * sampled. A miss is reported once and held pending until the walker
 * ends its walk.
 */
`timescale 1ns/1ns
`include "ptw_params.svh"

module tlb_lookup (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic [`PTW_ADDR_W-1:0] vadr_i,
	input  logic                   vadr_v_i,
	input  logic                   flush_i,
	input  logic                   fill_i,
	input  tlb_pkg::tlb_entry_t    fill_entry_i,
	input  logic                   walk_done_i,
	output logic [`PTW_ADDR_W-1:0] padr_o,
	output logic                   padr_v_o,
	output logic                   miss_o,
	output logic [`PTW_ADDR_W-1:0] miss_vadr_o
);
	import tlb_pkg::*;

	localparam int IDX_W = $clog2(`PTW_TLB_ENTRIES);
	localparam int SUP_W = `PTW_ADDR_W - `PTW_LOG_SUPER;

	tlb_entry_t             ent_q [`PTW_TLB_ENTRIES];
	logic [IDX_W-1:0]       victim_q;
	logic                   pending_q;
	logic                   served_q;
	logic                   hit;
	logic [`PTW_ADDR_W-1:0] hit_padr;

	// ====================
	// Associative compare
	// ====================
	always_comb begin
		hit = 1'b0;
		hit_padr = '0;
		for (int i = 0; i < `PTW_TLB_ENTRIES; i++) begin
			if (ent_q[i].valid && ent_q[i].is_super &&
			    ent_q[i].vtag[`PTW_ADDR_W-`PTW_LOG_PAGE-1 -: SUP_W] ==
			    vadr_i[`PTW_ADDR_W-1:`PTW_LOG_SUPER]) begin
				hit = 1'b1;
				hit_padr = {ent_q[i].ppn[`PTW_PPN_W-1 -: SUP_W],
				            vadr_i[`PTW_LOG_SUPER-1:0]};
			end
			if (ent_q[i].valid && !ent_q[i].is_super &&
			    ent_q[i].vtag == vadr_i[`PTW_ADDR_W-1:`PTW_LOG_PAGE]) begin
				hit = 1'b1;
				hit_padr = {ent_q[i].ppn, vadr_i[`PTW_LOG_PAGE-1:0]};
			end
		end
	end

	// ====================
	// Request and buffer state
	// ====================
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < `PTW_TLB_ENTRIES; i++) begin
				ent_q[i] <= '0;
			end
			victim_q <= '0;
			pending_q <= 1'b0;
			served_q <= 1'b0;
			padr_v_o <= 1'b0;
			miss_o <= 1'b0;
		end else begin
			padr_v_o <= 1'b0;
			miss_o <= 1'b0;
			// One answer per request, the requester drops valid in between
			if (!vadr_v_i) begin
				served_q <= 1'b0;
			end else if (!served_q && !pending_q) begin
				if (hit) begin
					padr_v_o <= 1'b1;
					served_q <= 1'b1;
				end else begin
					miss_o <= 1'b1;
					pending_q <= 1'b1;
				end
			end
			if (walk_done_i) begin
				pending_q <= 1'b0;
			end
			if (fill_i) begin
				ent_q[victim_q] <= fill_entry_i;
				victim_q <= victim_q + IDX_W'(1);
			end
			// Global entries survive a flush
			if (flush_i) begin
				for (int i = 0; i < `PTW_TLB_ENTRIES; i++) begin
					if (!ent_q[i].glb) begin
						ent_q[i].valid <= 1'b0;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (vadr_v_i) begin
			padr_o <= hit_padr;
			miss_vadr_o <= vadr_i;
		end
	end

endmodule

/* hdl/tlb_pkg.sv */
/*
 * Translation buffer types
 * One buffer entry holds a virtual page tag and its physical page.
 * Super entries compare only the upper ten bits of the tag.
 */
`include "ptw_params.svh"

package tlb_pkg;

	// 43 bits in total
	typedef struct packed {
		logic                                  valid;
		logic                                  is_super;
		logic                                  glb;
		logic [`PTW_ADDR_W-`PTW_LOG_PAGE-1:0]  vtag;
		logic [`PTW_PPN_W-1:0]                 ppn;
	} tlb_entry_t;

endpackage

/* hdl/wb_read_master.sv */
/*
 * Wishbone classic read master
 * Runs one single read per request and returns the data and the
 * error flag as a one-cycle done pulse.
 */
`timescale 1ns/1ns
`include "ptw_params.svh"

module wb_read_master (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   rd_req_i,
	input  logic [`PTW_ADDR_W-1:0] rd_adr_i,
	output logic                   rd_done_o,
	output logic [`PTW_ADDR_W-1:0] rd_data_o,
	output logic                   rd_err_o,
	output logic                   wb_cyc_o,
	output logic                   wb_stb_o,
	output logic [`PTW_ADDR_W-1:0] wb_adr_o,
	input  logic [`PTW_ADDR_W-1:0] wb_dat_i,
	input  logic                   wb_ack_i,
	input  logic                   wb_err_i
);
	logic cyc_q;
	logic term;

	// Either response ends the cycle
	assign term = cyc_q && (wb_ack_i || wb_err_i);
	assign wb_cyc_o = cyc_q;
	assign wb_stb_o = cyc_q;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cyc_q <= 1'b0;
			rd_done_o <= 1'b0;
		end else begin
			rd_done_o <= term;
			if (term) begin
				cyc_q <= 1'b0;
			end else if (!cyc_q && rd_req_i) begin
				cyc_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!cyc_q && rd_req_i) begin
			wb_adr_o <= rd_adr_i;
		end
		if (term) begin
			rd_data_o <= wb_dat_i;
			rd_err_o <= wb_err_i;
		end
	end

endmodule

/* include/ptw_params.svh */
/*
 * Page table walker sizes
 * Address and data width, page and superpage sizes, physical page
 * number width and the number of translation buffer entries.
 */
`ifndef PTW_PARAMS_SVH
`define PTW_PARAMS_SVH

// Address and data bus width
`define PTW_ADDR_W      32

// log2 of the 4 KB page and of the 4 MB superpage
`define PTW_LOG_PAGE    12
`define PTW_LOG_SUPER   22

`define PTW_PPN_W       20
`define PTW_TLB_ENTRIES 8

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the page table walker testbench with Verilator.
# The result is taken from the simulation log.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert --timing -f tb.f --top-module ptw_tb -o ptw_sim

# The run may stop early on a failed assertion, the log search decides
./obj_dir/ptw_sim +verilator+error+limit+1000 > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "test passed" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

/* tb.f */
+incdir+include
hdl/pte_pkg.sv
hdl/tlb_pkg.sv
hdl/tlb_lookup.sv
hdl/ptw_walker.sv
hdl/wb_read_master.sv
hdl/ptw_top.sv
test/ptw_mem_model.sv
test/ptw_props.sv
test/ptw_tb.sv

/* test/ptw_mem_model.sv */
/*
 * Wishbone classic slave memory for the page table walker
 * Holds the page tables in 16 KB, answers each read after a random
 * delay of zero to three cycles and counts the acknowledged reads.
 * Addresses beyond the memory end with a bus error.
 */
`timescale 1ns/1ns
`include "ptw_params.svh"

module ptw_mem_model (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   wb_cyc_i,
	input  logic                   wb_stb_i,
	input  logic [`PTW_ADDR_W-1:0] wb_adr_i,
	output logic [`PTW_ADDR_W-1:0] wb_dat_o,
	output logic                   wb_ack_o,
	output logic                   wb_err_o,
	output int                     read_cnt_o
);
	import pte_pkg::*;

	localparam int WORDS = 4096;

	logic [`PTW_ADDR_W-1:0] mem [WORDS];
	logic                   busy_q;
	logic [1:0]             wait_q;
	logic                   in_range;

	assign in_range = (wb_adr_i[`PTW_ADDR_W-1:14] == '0);

	function automatic logic [`PTW_ADDR_W-1:0] leaf_word(input logic [`PTW_PPN_W-1:0] ppn,
	                                                     input logic glb);
		pte_u p;
		p = '0;
		p.leaf_view.valid = 1'b1;
		p.leaf_view.leaf = 1'b1;
		p.leaf_view.glb = glb;
		p.leaf_view.ppn = ppn;
		return p;
	endfunction

	function automatic logic [`PTW_ADDR_W-1:0] ptr_word(input logic [`PTW_PPN_W-1:0] tpn);
		pte_u p;
		p = '0;
		p.ptr_view.valid = 1'b1;
		p.ptr_view.leaf = 1'b0;
		p.ptr_view.tpn = tpn;
		return p;
	endfunction

	// ====================
	// Page tables
	// ====================
	initial begin
		// Unused words carry their own index and a clear valid bit
		for (int i = 0; i < WORDS; i++) begin
			mem[i] = {20'(i), 12'h000};
		end
		// Top-level table at 0x1000, word 3 stays invalid
		mem[12'h400] = ptr_word(20'h00002);
		mem[12'h401] = leaf_word(20'h12C00, 1'b0);
		mem[12'h402] = leaf_word(20'h12C05, 1'b0);
		mem[12'h404] = ptr_word(20'h00003);
		mem[12'h405] = ptr_word(20'h00010);
		// Second-level table at 0x2000, word 10 is a misplaced pointer
		for (int k = 0; k < 10; k++) begin
			mem[12'h800 + k] = leaf_word(20'h80000 + 20'(k), 1'b0);
		end
		mem[12'h80A] = ptr_word(20'h00004);
		// Second-level table at 0x3000 with one global page
		mem[12'hC00] = leaf_word(20'h90000, 1'b1);
	end

	// ====================
	// Bus response
	// ====================
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy_q <= 1'b0;
			wait_q <= '0;
			wb_ack_o <= 1'b0;
			wb_err_o <= 1'b0;
			wb_dat_o <= '0;
			read_cnt_o <= 0;
		end else begin
			wb_ack_o <= 1'b0;
			wb_err_o <= 1'b0;
			// The master drops cyc on the edge that sees the response
			if (wb_ack_o || wb_err_o) begin
				busy_q <= 1'b0;
				if (wb_ack_o) begin
					read_cnt_o <= read_cnt_o + 1;
				end
			end else if (wb_cyc_i && wb_stb_i && !busy_q) begin
				busy_q <= 1'b1;
				wait_q <= 2'($urandom % 4);
			end else if (busy_q && wait_q != '0) begin
				wait_q <= wait_q - 2'd1;
			end else if (busy_q) begin
				wb_ack_o <= in_range;
				wb_err_o <= !in_range;
				wb_dat_o <= mem[wb_adr_i[13:2]];
			end
		end
	end

endmodule

/* test/ptw_props.sv */
/*
 * Bus and requester properties of the page table walker
 * Checks the Wishbone strobe and cycle rules and the shape of the
 * translation answer on the top-level ports.
 */
`timescale 1ns/1ns

module ptw_props (
	input logic clk,
	input logic rst_n_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_ack_i,
	input logic wb_err_i,
	input logic padr_v_i,
	input logic page_fault_i
);
	int fail_cnt = 0;

	stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n_i)
		wb_stb_i |-> wb_cyc_i)
		else begin
			$error("wb_stb_o high outside a bus cycle");
			fail_cnt++;
		end

	// A cycle only ends with a response
	cyc_held: assert property (@(posedge clk) disable iff (!rst_n_i)
		wb_cyc_i && !wb_ack_i && !wb_err_i |=> wb_cyc_i)
		else begin
			$error("wb_cyc_o dropped before ack or err");
			fail_cnt++;
		end

	padr_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
		padr_v_i |=> !padr_v_i)
		else begin
			$error("padr_v_o longer than one cycle");
			fail_cnt++;
		end

	fault_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
		$rose(page_fault_i) |-> !padr_v_i)
		else begin
			$error("padr_v_o high while page_fault_o rises");
			fail_cnt++;
		end

endmodule

bind ptw_top ptw_props u_props (
	.clk          (clk),
	.rst_n_i      (rst_n_i),
	.wb_cyc_i     (wb_cyc_o),
	.wb_stb_i     (wb_stb_o),
	.wb_ack_i     (wb_ack_i),
	.wb_err_i     (wb_err_i),
	.padr_v_i     (padr_v_o),
	.page_fault_i (page_fault_o)
);

/* test/ptw_tb.sv */
/*
 * Page table walker testbench
 * Runs a table of translations, flushes and fault clears against the
 * walker top level and a Wishbone memory holding the page tables.
 * Each row checks the physical address, the fault flag and the number
 * of memory reads that the row took.
 */
`timescale 1ns/1ns
`include "ptw_params.svh"

module ptw_tb;

	localparam int TIMEOUT = 200;
	localparam logic [1:0] OP_TRANS = 2'd0;
	localparam logic [1:0] OP_FLUSH = 2'd1;
	localparam logic [1:0] OP_CLEAR = 2'd2;

	typedef struct packed {
		logic [1:0]             op;
		logic [`PTW_ADDR_W-1:0] vadr;
		logic [`PTW_ADDR_W-1:0] padr;
		logic                   fault;
		logic [3:0]             reads;
	} row_t;

	logic                   clk;
	logic                   rst_n_i;
	logic [`PTW_ADDR_W-1:0] vadr_i;
	logic                   vadr_v_i;
	logic [`PTW_PPN_W-1:0]  ptbr_i;
	logic                   flush_i;
	logic                   clear_fault_i;
	logic [`PTW_ADDR_W-1:0] padr_o;
	logic                   padr_v_o;
	logic                   page_fault_o;
	logic                   wb_cyc_o;
	logic                   wb_stb_o;
	logic [`PTW_ADDR_W-1:0] wb_adr_o;
	logic [`PTW_ADDR_W-1:0] wb_dat_i;
	logic                   wb_ack_i;
	logic                   wb_err_i;
	int                     read_cnt;

	row_t rows[$];
	int   errors;
	int   rows_run;
	bit   timed_out;

	ptw_top UUT (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.vadr_i        (vadr_i),
		.vadr_v_i      (vadr_v_i),
		.ptbr_i        (ptbr_i),
		.flush_i       (flush_i),
		.clear_fault_i (clear_fault_i),
		.padr_o        (padr_o),
		.padr_v_o      (padr_v_o),
		.page_fault_o  (page_fault_o),
		.wb_cyc_o      (wb_cyc_o),
		.wb_stb_o      (wb_stb_o),
		.wb_adr_o      (wb_adr_o),
		.wb_dat_i      (wb_dat_i),
		.wb_ack_i      (wb_ack_i),
		.wb_err_i      (wb_err_i)
	);

	ptw_mem_model u_mem (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.wb_cyc_i   (wb_cyc_o),
		.wb_stb_i   (wb_stb_o),
		.wb_adr_i   (wb_adr_o),
		.wb_dat_o   (wb_dat_i),
		.wb_ack_o   (wb_ack_i),
		.wb_err_o   (wb_err_i),
		.read_cnt_o (read_cnt)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic row_t make_row(input logic [1:0] op, input logic [`PTW_ADDR_W-1:0] va,
	                                  input logic [`PTW_ADDR_W-1:0] pa, input logic flt,
	                                  input int rd);
		row_t r;
		r.op = op;
		r.vadr = va;
		r.padr = pa;
		r.fault = flt;
		r.reads = 4'(rd);
		return r;
	endfunction

	function automatic string op_name(input logic [1:0] op);
		if (op == OP_TRANS) begin
			return "translate";
		end else if (op == OP_FLUSH) begin
			return "flush";
		end
		return "clear fault";
	endfunction

	// ====================
	// Stimulus table
	// ====================
	// Tables: top level at 0x1000, second level at 0x2000 (pages 0x80000+k)
	// and 0x3000 (global page 0x90000), superpage 0x12C00 at top index 1
	task automatic fill_table();
		rows.push_back(make_row(OP_TRANS, 32'h00000ABC, 32'h80000ABC, 1'b0, 2));
		rows.push_back(make_row(OP_TRANS, 32'h00000ABC, 32'h80000ABC, 1'b0, 0));
		rows.push_back(make_row(OP_TRANS, 32'h00001123, 32'h80001123, 1'b0, 1));
		rows.push_back(make_row(OP_TRANS, 32'h00412345, 32'h12C12345, 1'b0, 1));
		rows.push_back(make_row(OP_TRANS, 32'h005ABCDE, 32'h12DABCDE, 1'b0, 0));
		// Misaligned superpage, then invalid top-level entry twice
		rows.push_back(make_row(OP_TRANS, 32'h00812345, 32'h0, 1'b1, 1));
		rows.push_back(make_row(OP_CLEAR, 32'h0, 32'h0, 1'b1, 0));
		rows.push_back(make_row(OP_TRANS, 32'h00C00000, 32'h0, 1'b1, 1));
		rows.push_back(make_row(OP_CLEAR, 32'h0, 32'h0, 1'b1, 0));
		rows.push_back(make_row(OP_TRANS, 32'h00C00000, 32'h0, 1'b1, 1));
		rows.push_back(make_row(OP_CLEAR, 32'h0, 32'h0, 1'b1, 0));
		// Pointer found at the second level
		rows.push_back(make_row(OP_TRANS, 32'h0000A000, 32'h0, 1'b1, 1));
		rows.push_back(make_row(OP_CLEAR, 32'h0, 32'h0, 1'b1, 0));
		rows.push_back(make_row(OP_TRANS, 32'h01000456, 32'h90000456, 1'b0, 2));
		// Invalid second-level entry under the remembered pointer
		rows.push_back(make_row(OP_TRANS, 32'h01001000, 32'h0, 1'b1, 1));
		rows.push_back(make_row(OP_CLEAR, 32'h0, 32'h0, 1'b1, 0));
		rows.push_back(make_row(OP_TRANS, 32'h01001000, 32'h0, 1'b1, 1));
		rows.push_back(make_row(OP_CLEAR, 32'h0, 32'h0, 1'b1, 0));
		// Second-level table outside the memory gives a bus error
		rows.push_back(make_row(OP_TRANS, 32'h01400000, 32'h0, 1'b1, 1));
		rows.push_back(make_row(OP_CLEAR, 32'h0, 32'h0, 1'b1, 0));
		rows.push_back(make_row(OP_FLUSH, 32'h0, 32'h0, 1'b0, 0));
		rows.push_back(make_row(OP_TRANS, 32'h00000ABC, 32'h80000ABC, 1'b0, 2));
		rows.push_back(make_row(OP_TRANS, 32'h01000456, 32'h90000456, 1'b0, 0));
		// Eight more pages push the first one out of the buffer
		for (int k = 1; k <= 8; k++) begin
			rows.push_back(make_row(OP_TRANS, {20'(k), 12'h010},
			                        {20'h80000 + 20'(k), 12'h010}, 1'b0, 1));
		end
		rows.push_back(make_row(OP_TRANS, 32'h00000ABC, 32'h80000ABC, 1'b0, 1));
	endtask

	// Holds the request until an answer or a fault comes back
	task automatic translate(input logic [`PTW_ADDR_W-1:0] va,
	                         output logic [`PTW_ADDR_W-1:0] pa, output logic flt);
		int cycles;
		@(negedge clk);
		vadr_i = va;
		vadr_v_i = 1'b1;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!padr_v_o && !page_fault_o && cycles < TIMEOUT);
		if (!padr_v_o && !page_fault_o) begin
			$display("Timeout: no translation and no fault for vadr %h", va);
			timed_out = 1'b1;
		end
		pa = padr_o;
		flt = page_fault_o;
		vadr_v_i = 1'b0;
	endtask

	task automatic run_row(input int idx, input row_t rw);
		int                     start_cnt;
		int                     row_err;
		int                     cycles;
		logic                   got_fault;
		logic [`PTW_ADDR_W-1:0] got_padr;
		start_cnt = read_cnt;
		row_err = 0;
		got_padr = '0;
		got_fault = 1'b0;
		case (rw.op)
			OP_TRANS: begin
				translate(rw.vadr, got_padr, got_fault);
			end
			OP_FLUSH: begin
				@(negedge clk);
				flush_i = 1'b1;
				@(negedge clk);
				flush_i = 1'b0;
				got_fault = page_fault_o;
			end
			default: begin
				@(negedge clk);
				// The fault was raised cycles ago, so this shows it held
				got_fault = page_fault_o;
				clear_fault_i = 1'b1;
				@(negedge clk);
				clear_fault_i = 1'b0;
				cycles = 0;
				while (page_fault_o && cycles < TIMEOUT) begin
					@(negedge clk);
					cycles++;
				end
				if (page_fault_o) begin
					$display("Timeout: page fault flag did not clear");
					timed_out = 1'b1;
				end
			end
		endcase
		if (!timed_out) begin
			assert (got_fault == rw.fault) else begin
				$display("Fail at %0t ns: row %0d fault flag %0b, expected %0b",
				         $time, idx, got_fault, rw.fault);
				row_err++;
			end
			if (rw.op == OP_TRANS && !rw.fault) begin
				assert (got_padr == rw.padr) else begin
					$display("Fail at %0t ns: row %0d vadr %h gave padr %h, expected %h",
					         $time, idx, rw.vadr, got_padr, rw.padr);
					row_err++;
				end
			end
			assert (read_cnt - start_cnt == int'(rw.reads)) else begin
				$display("Fail at %0t ns: row %0d took %0d reads, expected %0d",
				         $time, idx, read_cnt - start_cnt, rw.reads);
				row_err++;
			end
		end
		errors += row_err;
		$display("row %0d %s vadr %h: %s", idx, op_name(rw.op), rw.vadr,
		         (row_err == 0 && !timed_out) ? "ok" : "error");
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		void'($urandom(32'h50c4));
		rst_n_i = 1'b0;
		vadr_i = '0;
		vadr_v_i = 1'b0;
		ptbr_i = 20'h00001;
		flush_i = 1'b0;
		clear_fault_i = 1'b0;
		errors = 0;
		rows_run = 0;
		timed_out = 1'b0;
		fill_table();
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;
		for (int r = 0; r < rows.size(); r++) begin
			run_row(r, rows[r]);
			rows_run++;
			if (timed_out) begin
				break;
			end
		end
		repeat (2) @(negedge clk);
		$display("rows run %0d of %0d, errors %0d, assertion failures %0d",
		         rows_run, rows.size(), errors, UUT.u_props.fail_cnt);
		if (errors == 0 && !timed_out && UUT.u_props.fail_cnt == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule
